/* list.f */
src/rv32i_pkg.sv
src/tomasulo_pkg.sv
src/rob_ifs.sv
src/mem_commit.sv
src/reg_status.sv
src/rob.sv
src/rob_top.sv
testbench/rob_checker.sv
testbench/tb_rob.sv

/* testbench/tb_rob.sv */
`timescale 1ns/10ps

module tb_rob;
    import rv32i_pkg::*;
    import tomasulo_pkg::*;

    localparam int rob_depth    = 8;
    localparam int tw           = $clog2(rob_depth);
    localparam int phase_cycles = 300;
    localparam int num_phases   = 5;
    // every phase plus reset and a safety margin
    localparam int cycle_limit  = num_phases * phase_cycles + 8 + 200;

    logic                 clk;
    logic                 rst;
    logic                 rob_load;
    op_t                  instr_type;
    reg_idx_t             rd;
    reg_idx_t             st_src;
    logic [rob_depth-1:0] set_rob_valid;
    logic                 update_br;
    logic [tw-1:0]        br_entry;
    logic                 br_taken;
    logic                 data_mem_resp;
    logic [1:0]           memaddr_offset;
    reg_idx_t             query_reg;
    logic [tw-1:0]        alloc_tag;
    logic                 rob_full;
    logic                 data_read;
    logic                 data_write;
    logic [3:0]           wmask;
    logic                 regfile_load;
    logic                 ld_commit_sel;
    reg_idx_t             rd_commit;
    logic [tw-1:0]        commit_tag;
    logic                 ld_pc;
    logic                 flush_in_prog;
    logic                 query_busy;
    logic [tw-1:0]        query_tag;

    integer seed = 56;
    int     wait_cnt;
    int     cycles;

    rob_top #(.rob_depth(rob_depth)) dut (.*);
    rob_checker #(.rob_depth(rob_depth)) chk (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // op mix per phase, values 8..15 are all memory ops
    function automatic op_t pick_op(int mix);
        int r;
        r = {$random(seed)} % 13;
        case (mix)
            0:       return op_t'(r % 4);
            1:       return op_t'(8 + r % 8);
            2:       return (r % 2) ? branch : op_t'(r % 4);
            default: return (r < 4) ? op_t'(r) : (r == 4) ? branch : op_t'(r + 3);
        endcase
    endfunction

    task automatic drive_cycle(int mix);
        op_t                  op;
        logic [rob_depth-1:0] valid;
        logic                 br_done;
        @(posedge clk);
        op = pick_op(mix);
        rob_load   <= !chk.full_now() && ({$random(seed)} % 4 != 0);
        instr_type <= op;
        // prediction rides in bit 1, bit 0 clear until resolved
        rd     <= (op == branch) ? reg_idx_t'(({$random(seed)} % 2) * 2)
                                 : reg_idx_t'($random(seed));
        st_src <= reg_idx_t'($random(seed));

        // complete random live entries, branches go one per cycle below
        valid = rob_depth'($random(seed)) & chk.m_alloc & ~chk.m_done;
        for (int t = 0; t < rob_depth; t++) begin
            if (chk.m_op[t] == branch) begin
                valid[t] = 1'b0;
            end
        end
        br_done = 1'b0;
        update_br <= 1'b0;
        if (chk.m_alloc[chk.m_br] && !chk.m_done[chk.m_br] && ({$random(seed)} % 3 == 0)) begin
            valid[chk.m_br] = 1'b1;
            br_done = 1'b1;
            update_br <= 1'b1;
            br_entry  <= chk.m_br;
            br_taken  <= 1'($random(seed));
        end
        for (int t = 0; t < rob_depth; t++) begin
            if (!br_done && chk.m_alloc[t] && !chk.m_done[t] && (chk.m_op[t] == branch)
                && (tw'(t) != chk.m_br)) begin
                // older branch, resolved as predicted
                valid[t] = 1'b1;
                br_done = 1'b1;
                update_br <= 1'b1;
                br_entry  <= tw'(t);
                br_taken  <= chk.m_reg[t][1];
            end
        end
        set_rob_valid <= valid;

        // cache answers after a random delay
        if (data_mem_resp) begin
            data_mem_resp <= 1'b0;
            wait_cnt = {$random(seed)} % 4;
        end else if (chk.mem_head_now()) begin
            if (wait_cnt == 0) begin
                data_mem_resp <= 1'b1;
            end else begin
                wait_cnt--;
            end
        end
        memaddr_offset <= (chk.m_op[chk.m_head] == sh) ? 2'(({$random(seed)} % 2) * 2)
                                                       : 2'($random(seed));
        query_reg <= reg_idx_t'($random(seed));
    endtask

    task automatic run_phase(string name, int mix);
        chk.start_test(name);
        repeat (phase_cycles) begin
            drive_cycle(mix);
        end
        chk.end_test();
    endtask

    // run limit
    initial begin
        cycles = 0;
        while (cycles <= cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run still going after %0d cycles", cycle_limit);
        $display("sim failed");
        $finish;
    end

    initial begin
        rst            = 1'b1;
        rob_load       = 1'b0;
        instr_type     = alu;
        rd             = '0;
        st_src         = '0;
        set_rob_valid  = '0;
        update_br      = 1'b0;
        br_entry       = '0;
        br_taken       = 1'b0;
        data_mem_resp  = 1'b0;
        memaddr_offset = '0;
        query_reg      = '0;
        wait_cnt       = 0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        // outputs must sit at their reset values
        chk.start_test("reset");
        repeat (4) @(posedge clk);
        chk.end_test();
        run_phase("alu_stream", 0);
        run_phase("memory", 1);
        run_phase("branch", 2);
        run_phase("mixed", 3);
        $display("summary: %0d tests, %0d failed, %0d mismatches", chk.test_count,
                 chk.failed_tests, chk.total_errors);
        if ((chk.failed_tests == 0) && (chk.total_errors == 0)) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* testbench/rob_checker.sv */
`timescale 1ns/10ps

module rob_checker #(
    parameter int rob_depth = 8
) (
    input logic                         clk,
    input logic                         rst,
    input logic                         rob_load,
    input tomasulo_pkg::op_t            instr_type,
    input rv32i_pkg::reg_idx_t          rd,
    input rv32i_pkg::reg_idx_t          st_src,
    input logic [rob_depth-1:0]         set_rob_valid,
    input logic                         update_br,
    input logic [$clog2(rob_depth)-1:0] br_entry,
    input logic                         br_taken,
    input logic                         data_mem_resp,
    input logic [1:0]                   memaddr_offset,
    input logic [$clog2(rob_depth)-1:0] alloc_tag,
    input logic                         rob_full,
    input logic                         data_read,
    input logic                         data_write,
    input logic [3:0]                   wmask,
    input logic                         regfile_load,
    input logic                         ld_commit_sel,
    input rv32i_pkg::reg_idx_t          rd_commit,
    input logic [$clog2(rob_depth)-1:0] commit_tag,
    input logic                         ld_pc,
    input logic                         flush_in_prog,
    input rv32i_pkg::reg_idx_t          query_reg,
    input logic                         query_busy,
    input logic [$clog2(rob_depth)-1:0] query_tag
);
    import rv32i_pkg::*;
    import tomasulo_pkg::*;

    localparam int tw = $clog2(rob_depth);

    // buffer model
    op_t                  m_op  [rob_depth];
    reg_idx_t             m_reg [rob_depth];
    logic [rob_depth-1:0] m_alloc;
    logic [rob_depth-1:0] m_done;
    logic [tw-1:0]        m_head;
    logic [tw-1:0]        m_curr;
    logic [tw-1:0]        m_br;
    logic [tw-1:0]        m_fptr;
    logic [tw-1:0]        flush_br;
    logic                 m_flush;
    logic                 was_flush;
    // register table model
    logic [num_regs-1:0]  m_busy;
    logic [tw-1:0]        m_tag [num_regs];

    string test_name = "reset";
    int    checks;
    int    errors;
    int    younger;
    int    flush_cycles;
    int    test_count;
    int    failed_tests;
    int    total_errors;

    function automatic logic store_op(op_t op);
        return (op == sb) || (op == sh) || (op == sw);
    endfunction

    function automatic logic load_op(op_t op);
        return (op == lb) || (op == lh) || (op == lw) || (op == lbu) || (op == lhu);
    endfunction

    // branch and store have no destination
    function automatic logic reg_writer(op_t op);
        return !(store_op(op) || (op == branch));
    endfunction

    function automatic logic mispredict_now();
        return !m_flush && m_alloc[m_br] && m_done[m_br] && (m_op[m_br] == branch)
               && (m_reg[m_br][1] != m_reg[m_br][0]);
    endfunction

    function automatic logic full_now();
        logic [tw-1:0] used;
        used = m_curr - m_head;
        return (used == tw'(rob_depth - 1)) || mispredict_now() || m_flush;
    endfunction

    function automatic logic head_ready_now();
        return m_alloc[m_head] && m_done[m_head] && !mispredict_now() && !m_flush;
    endfunction

    // head is a load or store waiting on the cache
    function automatic logic mem_head_now();
        return head_ready_now() && (load_op(m_op[m_head]) || store_op(m_op[m_head]));
    endfunction

    task automatic check_value(string what, logic [31:0] exp, logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("MISMATCH %s %s expected %0h actual %0h", test_name, what, exp, act);
        end
    endtask

    task automatic start_test(string name);
        test_name = name;
        checks    = 0;
        errors    = 0;
    endtask

    task automatic end_test();
        test_count++;
        total_errors += errors;
        if (errors != 0) begin
            failed_tests++;
        end
        $display("test %s: %0d checks, %0d mismatches, %s", test_name, checks, errors,
                 (errors == 0) ? "ok" : "FAILED");
    endtask

    // compare mid-cycle, then step the model across the next edge
    always @(negedge clk) begin
        op_t        hop;
        logic       misp;
        logic       ready;
        logic       ld;
        logic       st;
        logic       retire;
        logic       alloc_ok;
        logic [3:0] exp_mask;
        int         lane_lo;
        int         lane_n;
        if (rst) begin
            m_head       = '0;
            m_curr       = '0;
            m_br         = '0;
            m_fptr       = '0;
            m_flush      = 1'b0;
            was_flush    = 1'b0;
            m_alloc      = '0;
            m_done       = '0;
            m_busy       = '0;
            flush_cycles = 0;
        end else begin
            hop      = m_op[m_head];
            misp     = mispredict_now();
            ready    = head_ready_now();
            ld       = ready && load_op(hop);
            st       = ready && store_op(hop);
            retire   = ready && (!(ld || st) || data_mem_resp);
            alloc_ok = rob_load && !full_now();

            check_value("alloc_tag", m_curr, alloc_tag);
            check_value("rob_full", full_now(), rob_full);
            check_value("ld_pc", misp, ld_pc);
            check_value("flush_in_prog", m_flush, flush_in_prog);
            check_value("data_read", ld && !data_mem_resp, data_read);
            check_value("data_write", st && !data_mem_resp, data_write);
            check_value("ld_commit_sel", ld && data_mem_resp, ld_commit_sel);
            check_value("regfile_load", retire && reg_writer(hop), regfile_load);
            check_value("commit_tag", m_head, commit_tag);
            if (retire) begin
                check_value("rd_commit", m_reg[m_head], rd_commit);
            end
            if (ready) begin
                // no byte lanes unless the head is a store
                exp_mask = 4'b0000;
                if (store_op(hop)) begin
                    // sw covers the word, sh and sb start at the offset
                    lane_lo = (hop == sw) ? 0 : int'(memaddr_offset);
                    lane_n  = (hop == sw) ? 4 : (hop == sh) ? 2 : 1;
                    for (int i = 0; i < 4; i++) begin
                        exp_mask[i] = (i >= lane_lo) && (i < lane_lo + lane_n);
                    end
                end
                check_value("wmask", exp_mask, wmask);
            end
            check_value("query_busy", m_busy[query_reg], query_busy);
            check_value("query_tag", m_busy[query_reg] ? m_tag[query_reg] : '0, query_tag);

            // flush length and refill point, once the walk is over
            if (was_flush && !m_flush) begin
                check_value("flush_length", (younger == 0) ? 1 : younger, flush_cycles);
                check_value("refill_tag", tw'(flush_br + 1'b1), alloc_tag);
                flush_cycles = 0;
            end
            if (flush_in_prog) begin
                flush_cycles++;
            end
            was_flush = m_flush;

            // register table, releases first so allocation wins
            if (retire && reg_writer(hop) && (m_tag[m_reg[m_head]] == m_head)) begin
                m_busy[m_reg[m_head]] = 1'b0;
            end
            if (m_flush && (m_fptr != m_curr) && reg_writer(m_op[m_fptr])
                && (m_tag[m_reg[m_fptr]] == m_fptr)) begin
                m_busy[m_reg[m_fptr]] = 1'b0;
            end
            if (alloc_ok && reg_writer(instr_type) && (rd != '0)) begin
                m_busy[rd] = 1'b1;
                m_tag[rd]  = m_curr;
            end

            // buffer entries
            if (alloc_ok) begin
                m_op[m_curr]    = instr_type;
                m_reg[m_curr]   = store_op(instr_type) ? st_src : rd;
                m_alloc[m_curr] = 1'b1;
                m_done[m_curr]  = 1'b0;
                if (instr_type == branch) begin
                    m_br = m_curr;
                end
                m_curr = m_curr + 1'b1;
            end
            m_done = m_done | set_rob_valid;
            if (update_br) begin
                m_reg[br_entry][0] = m_reg[br_entry][0] | br_taken;
            end
            if (retire) begin
                m_alloc[m_head] = 1'b0;
                m_done[m_head]  = 1'b0;
                m_head          = m_head + 1'b1;
            end
            if (misp) begin
                m_flush           = 1'b1;
                flush_br          = m_br;
                m_fptr            = m_br + 1'b1;
                younger           = int'(tw'(m_curr - m_br - 1'b1));
                // resolved branch then retires as predicted
                m_reg[m_br][1]    = m_reg[m_br][0];
            end else if (m_flush) begin
                if (m_fptr != m_curr) begin
                    m_alloc[m_fptr] = 1'b0;
                    m_done[m_fptr]  = 1'b0;
                end
                if ((m_fptr == m_curr) || (tw'(m_fptr + 1'b1) == m_curr)) begin
                    m_flush = 1'b0;
                    m_curr  = flush_br + 1'b1;
                end else begin
                    m_fptr = m_fptr + 1'b1;
                end
            end
        end
    end

endmodule

/* src/rob_top.sv */
`timescale 1ns/10ps

module rob_top #(
    parameter int rob_depth = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    // dispatch from the instruction queue
    input  logic                         rob_load,
    input  tomasulo_pkg::op_t            instr_type,
    input  rv32i_pkg::reg_idx_t          rd,
    input  rv32i_pkg::reg_idx_t          st_src,
    output logic [$clog2(rob_depth)-1:0] alloc_tag,
    output logic                         rob_full,
    // completion from reservation stations and branch unit
    input  logic [rob_depth-1:0]         set_rob_valid,
    input  logic                         update_br,
    input  logic [$clog2(rob_depth)-1:0] br_entry,
    input  logic                         br_taken,
    // data cache
    input  logic                         data_mem_resp,
    input  logic [1:0]                   memaddr_offset,
    output logic                         data_read,
    output logic                         data_write,
    output logic [3:0]                   wmask,
    // commit to the register file
    output logic                         regfile_load,
    output logic                         ld_commit_sel,
    output rv32i_pkg::reg_idx_t          rd_commit,
    output logic [$clog2(rob_depth)-1:0] commit_tag,
    // fetch redirect and recovery state
    output logic                         ld_pc,
    output logic                         flush_in_prog,
    // operand lookup
    input  rv32i_pkg::reg_idx_t          query_reg,
    output logic                         query_busy,
    output logic [$clog2(rob_depth)-1:0] query_tag
);

    rename_if #(.rob_depth(rob_depth)) rename_bus ();
    mem_commit_if mem_bus (.clk(clk), .rst(rst));

    rob #(.rob_depth(rob_depth)) u_rob (
        .clk           (clk),
        .rst           (rst),
        .rob_load      (rob_load),
        .instr_type    (instr_type),
        .rd            (rd),
        .st_src        (st_src),
        .set_rob_valid (set_rob_valid),
        .update_br     (update_br),
        .br_entry      (br_entry),
        .br_taken      (br_taken),
        .alloc_tag     (alloc_tag),
        .rob_full      (rob_full),
        .ld_pc         (ld_pc),
        .flush_in_prog (flush_in_prog),
        .rd_commit     (rd_commit),
        .commit_tag    (commit_tag),
        .rename        (rename_bus),
        .mem           (mem_bus)
    );

    mem_commit u_mem_commit (
        .head           (mem_bus),
        .data_mem_resp  (data_mem_resp),
        .memaddr_offset (memaddr_offset),
        .data_read      (data_read),
        .data_write     (data_write),
        .wmask          (wmask),
        .ld_commit_sel  (ld_commit_sel)
    );

    reg_status #(.rob_depth(rob_depth)) u_reg_status (
        .clk        (clk),
        .rst        (rst),
        .rename     (rename_bus),
        .query_reg  (query_reg),
        .query_busy (query_busy),
        .query_tag  (query_tag)
    );

    // register file write enable rides on the rename bus
    assign regfile_load = rename_bus.regfile_load;

endmodule

/* src/rob.sv */
`timescale 1ns/10ps

module rob #(
    parameter int rob_depth = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         rob_load,
    input  tomasulo_pkg::op_t            instr_type,
    input  rv32i_pkg::reg_idx_t          rd,
    input  rv32i_pkg::reg_idx_t          st_src,
    input  logic [rob_depth-1:0]         set_rob_valid,
    input  logic                         update_br,
    input  logic [$clog2(rob_depth)-1:0] br_entry,
    input  logic                         br_taken,
    output logic [$clog2(rob_depth)-1:0] alloc_tag,
    output logic                         rob_full,
    output logic                         ld_pc,
    output logic                         flush_in_prog,
    output rv32i_pkg::reg_idx_t          rd_commit,
    output logic [$clog2(rob_depth)-1:0] commit_tag,
    rename_if.rob                        rename,
    mem_commit_if.rob                    mem
);
    import rv32i_pkg::*;
    import tomasulo_pkg::*;

    localparam int tag_w = $clog2(rob_depth);
    // one slot stays free so head == curr always means empty
    localparam logic [tag_w-1:0] last_slot = tag_w'(rob_depth - 1);

    // per-entry payload
    op_t      op_arr  [rob_depth];
    reg_idx_t reg_arr [rob_depth];

    // per-entry control
    logic [rob_depth-1:0] done_arr;
    logic [rob_depth-1:0] alloc_arr;

    logic [tag_w-1:0] head_ptr;
    logic [tag_w-1:0] curr_ptr;
    logic [tag_w-1:0] br_ptr;
    logic [tag_w-1:0] flush_ptr;
    logic [tag_w-1:0] next_flush;
    logic [tag_w-1:0] used_cnt;

    logic flush_ip;
    logic mispredict;
    logic do_alloc;
    logic retire;
    logic walk_end;
    op_t  head_op;

    assign used_cnt   = curr_ptr - head_ptr;
    assign next_flush = flush_ptr + 1'b1;
    assign head_op    = op_arr[head_ptr];

    // tracked branch done and outcome bit 0 disagrees with prediction bit 1
    assign mispredict = !flush_ip && alloc_arr[br_ptr] && done_arr[br_ptr]
                        && (op_arr[br_ptr] == branch)
                        && (reg_arr[br_ptr][1] != reg_arr[br_ptr][0]);

    // dispatch stalls while recovering so curr_ptr stays put
    assign rob_full = (used_cnt == last_slot) || mispredict || flush_ip;
    assign do_alloc = rob_load && !rob_full;

    // walk ends on the last younger entry, or at once if there is none
    assign walk_end = (flush_ptr == curr_ptr) || (next_flush == curr_ptr);

    assign mem.head_op    = head_op;
    assign mem.head_ready = alloc_arr[head_ptr] && done_arr[head_ptr]
                            && !mispredict && !flush_ip;
    // memory ops retire on done, everything else unless held
    assign retire = mem.head_ready && (mem.mem_done || !mem.mem_hold);

    assign alloc_tag     = curr_ptr;
    assign ld_pc         = mispredict;
    assign flush_in_prog = flush_ip;
    assign rd_commit     = reg_arr[head_ptr];
    assign commit_tag    = head_ptr;

    // rename side, table decides which ops really own a register
    assign rename.alloc     = do_alloc;
    assign rename.alloc_reg = rd;
    assign rename.alloc_op  = instr_type;
    assign rename.alloc_tag = curr_ptr;

    assign rename.regfile_load = retire && writes_reg(head_op);
    assign rename.commit_reg   = reg_arr[head_ptr];
    assign rename.commit_tag   = head_ptr;

    // one discard per walk cycle, only for register writers
    assign rename.reallocate_reg_tag = flush_ip && (flush_ptr != curr_ptr)
                                       && writes_reg(op_arr[flush_ptr]);
    assign rename.discard_reg        = reg_arr[flush_ptr];
    assign rename.discard_tag        = flush_ptr;

    always_ff @(posedge clk) begin
        if (rst) begin
            head_ptr  <= '0;
            curr_ptr  <= '0;
            br_ptr    <= '0;
            flush_ptr <= '0;
            flush_ip  <= 1'b0;
            alloc_arr <= '0;
            done_arr  <= '0;
        end else begin
            if (do_alloc) begin
                op_arr[curr_ptr]    <= instr_type;
                // stores keep the data source register instead of rd
                reg_arr[curr_ptr]   <= is_store(instr_type) ? st_src : rd;
                alloc_arr[curr_ptr] <= 1'b1;
                done_arr[curr_ptr]  <= 1'b0;
                curr_ptr            <= curr_ptr + 1'b1;
                // only the youngest branch is tracked
                if (instr_type == branch) begin
                    br_ptr <= curr_ptr;
                end
            end

            // completion strobes from the reservation stations
            for (int i = 0; i < rob_depth; i++) begin
                if (set_rob_valid[i]) begin
                    done_arr[i] <= 1'b1;
                end
            end

            // actual branch outcome lands in bit 0
            if (update_br) begin
                reg_arr[br_entry][0] <= reg_arr[br_entry][0] | br_taken;
            end

            if (retire) begin
                alloc_arr[head_ptr] <= 1'b0;
                done_arr[head_ptr]  <= 1'b0;
                head_ptr            <= head_ptr + 1'b1;
            end

            if (mispredict) begin
                flush_ip  <= 1'b1;
                flush_ptr <= br_ptr + 1'b1;
                // align prediction with outcome, branch then retires normally
                reg_arr[br_ptr][1] <= reg_arr[br_ptr][0];
            end else if (flush_ip) begin
                if (flush_ptr != curr_ptr) begin
                    alloc_arr[flush_ptr] <= 1'b0;
                    done_arr[flush_ptr]  <= 1'b0;
                end
                if (walk_end) begin
                    flush_ip <= 1'b0;
                    // refill right behind the resolved branch
                    curr_ptr <= br_ptr + 1'b1;
                end else begin
                    flush_ptr <= next_flush;
                end
            end
        end
    end

    // a dispatch never lands on a live entry
    a_alloc_free: assert property (@(posedge clk) disable iff (rst)
        do_alloc |-> !alloc_arr[curr_ptr])
        else $error("rob allocated over a live entry");

    // head never runs past curr_ptr
    a_head_bound: assert property (@(posedge clk) disable iff (rst)
        retire |-> (used_cnt != '0))
        else $error("rob retired from an empty buffer");

    // the walk only discards live entries and never the head
    a_walk_live: assert property (@(posedge clk) disable iff (rst)
        (flush_ip && (flush_ptr != curr_ptr))
        |-> (alloc_arr[flush_ptr] && (flush_ptr != head_ptr)))
        else $error("flush walk reached a free entry or the head");

endmodule

/* src/reg_status.sv */
`timescale 1ns/10ps

module reg_status #(
    parameter int rob_depth = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    rename_if.status                     rename,
    input  rv32i_pkg::reg_idx_t          query_reg,
    output logic                         query_busy,
    output logic [$clog2(rob_depth)-1:0] query_tag
);
    import rv32i_pkg::*;
    import tomasulo_pkg::*;

    localparam int tag_w = $clog2(rob_depth);

    // busy bit and last in-flight writer per architectural register
    logic [num_regs-1:0] busy;
    logic [tag_w-1:0]    tag_arr [num_regs];

    logic alloc_set;
    logic commit_clr;
    logic discard_clr;

    // x0 and non-writing ops never claim a register
    assign alloc_set = rename.alloc && writes_reg(rename.alloc_op)
                       && (rename.alloc_reg != zero_reg);

    // release only if the retiring entry is still the owner
    assign commit_clr = rename.regfile_load
                        && (tag_arr[rename.commit_reg] == rename.commit_tag);

    // discarded owner just drops busy, older writers are not restored
    assign discard_clr = rename.reallocate_reg_tag
                         && (tag_arr[rename.discard_reg] == rename.discard_tag);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            if (commit_clr) begin
                busy[rename.commit_reg] <= 1'b0;
            end
            if (discard_clr) begin
                busy[rename.discard_reg] <= 1'b0;
            end
            // placed last so a same-cycle allocation wins over a release
            if (alloc_set) begin
                busy[rename.alloc_reg]    <= 1'b1;
                tag_arr[rename.alloc_reg] <= rename.alloc_tag;
            end
        end
    end

    // operand lookup for the issue stage
    assign query_busy = busy[query_reg];
    // tag only meaningful while busy
    assign query_tag  = query_busy ? tag_arr[query_reg] : '0;

endmodule

/* src/mem_commit.sv */
`timescale 1ns/10ps

module mem_commit (
    mem_commit_if.mem  head,
    input  logic       data_mem_resp,
    input  logic [1:0] memaddr_offset,
    output logic       data_read,
    output logic       data_write,
    output logic [3:0] wmask,
    output logic       ld_commit_sel
);
    import tomasulo_pkg::*;

    logic ld_head;
    logic st_head;
    logic mem_head;

    // ready head split by op class
    assign ld_head  = head.head_ready && is_load(head.head_op);
    assign st_head  = head.head_ready && is_store(head.head_op);
    assign mem_head = ld_head || st_head;

    // request levels held until the cache answers
    assign data_read  = ld_head && !data_mem_resp;
    assign data_write = st_head && !data_mem_resp;

    // hold the head while waiting, release on the response cycle
    assign head.mem_hold = mem_head && !data_mem_resp;
    assign head.mem_done = mem_head && data_mem_resp;

    // load result comes from the cache, not the cdb
    assign ld_commit_sel = ld_head && data_mem_resp;

    // byte lanes from store width and low address bits
    always_comb begin
        case (head.head_op)
            sw:      wmask = 4'b1111;
            sh:      wmask = 4'b0011 << memaddr_offset;
            sb:      wmask = 4'b0001 << memaddr_offset;
            default: wmask = 4'b0000;
        endcase
    end

    // a pending read never turns into a write
    a_rw_excl: assert property (@(posedge head.clk) disable iff (head.rst)
        data_read |=> !data_write)
        else $error("data_write followed an unanswered data_read");

    // a held head keeps its op until the cache answers
    a_head_held: assert property (@(posedge head.clk) disable iff (head.rst)
        head.mem_hold |=> $stable(head.head_op))
        else $error("head op changed while waiting on the cache");

endmodule

/* src/rob_ifs.sv */
`timescale 1ns/10ps

// rename traffic from the reorder buffer to the register status table
interface rename_if #(
    parameter int rob_depth = 8
);
    import rv32i_pkg::*;
    import tomasulo_pkg::*;

    localparam int tag_w = $clog2(rob_depth);

    // new entry written at dispatch
    logic             alloc;
    reg_idx_t         alloc_reg;
    op_t              alloc_op;
    logic [tag_w-1:0] alloc_tag;

    // head entry retiring into the register file
    logic             regfile_load;
    reg_idx_t         commit_reg;
    logic [tag_w-1:0] commit_tag;

    // younger entry thrown away by the flush walk
    logic             reallocate_reg_tag;
    reg_idx_t         discard_reg;
    logic [tag_w-1:0] discard_tag;

    modport rob (
        output alloc, alloc_reg, alloc_op, alloc_tag,
        output regfile_load, commit_reg, commit_tag,
        output reallocate_reg_tag, discard_reg, discard_tag
    );

    modport status (
        input alloc, alloc_reg, alloc_op, alloc_tag,
        input regfile_load, commit_reg, commit_tag,
        input reallocate_reg_tag, discard_reg, discard_tag
    );

endinterface

// head entry handshake between the reorder buffer and the cache commit logic
interface mem_commit_if (
    input logic clk,
    input logic rst
);
    import tomasulo_pkg::*;

    // head complete and no recovery running
    logic head_ready;
    op_t  head_op;
    // memory op at head still waiting on the cache
    logic mem_hold;
    // cache answered, head may retire
    logic mem_done;

    modport rob (
        output head_ready, head_op,
        input  mem_hold, mem_done
    );

    modport mem (
        input  clk, rst,
        input  head_ready, head_op,
        output mem_hold, mem_done
    );

endinterface

/* src/tomasulo_pkg.sv */
package tomasulo_pkg;

    // operation class carried by every reorder buffer entry
    // stores and loads sit in two contiguous ranges
    typedef enum logic [3:0] {
        alu    = 4'd0,
        lui    = 4'd1,
        auipc  = 4'd2,
        jal    = 4'd3,
        branch = 4'd4,
        sb     = 4'd8,
        sh     = 4'd9,
        sw     = 4'd10,
        lb     = 4'd11,
        lh     = 4'd12,
        lw     = 4'd13,
        lbu    = 4'd14,
        lhu    = 4'd15
    } op_t;

    // store range sb .. sw
    function automatic logic is_store(op_t op);
        return (op >= sb) && (op <= sw);
    endfunction

    // load range lb .. lhu
    function automatic logic is_load(op_t op);
        return (op >= lb) && (op <= lhu);
    endfunction

    // branches and stores leave the register file alone
    function automatic logic writes_reg(op_t op);
        return (op != branch) && !is_store(op);
    endfunction

endpackage

/* src/rv32i_pkg.sv */
package rv32i_pkg;

    // base integer word width
    // kept for reference, the commit side carries no data
    parameter int xlen = 32;

    // architectural register file
    parameter int num_regs = 32;

    // index width follows the register count
    parameter int reg_idx_w = $clog2(num_regs);

    // register index as decoded from rd, rs1, rs2
    typedef logic [reg_idx_w-1:0] reg_idx_t;

    // x0 is hardwired to zero
    parameter reg_idx_t zero_reg = '0;

endpackage
